//--- src/sdc_pkg.sv
// SDRAM bank controller shared definitions
// command codes, timing fields, mode word decoding and init constants

package sdc_pkg;

	////////////////////////////////////////////////////////////////////////////
	// command bus, encoded as {ras_n, cas_n, we_n}
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {
		CMD_LOAD_MR      = 3'b000,
		CMD_AUTO_REFRESH = 3'b001,
		CMD_PRECHARGE    = 3'b010,
		CMD_ACTIVE       = 3'b011,
		CMD_WRITE        = 3'b100,
		CMD_READ         = 3'b101,
		CMD_NOP          = 3'b111
	} sdc_cmd_e;

	// delays in clock cycles, each at least 1
	typedef struct packed {
		logic [3:0] trp;   // precharge to activate/refresh
		logic [3:0] trcd;  // activate to read/write
		logic [3:0] trca;  // refresh to next command
		logic [3:0] twr;   // last write beat to precharge
	} sdc_timing_t;

	////////////////////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////////////////////
	localparam int BL_CODE_W  = 3;   // burst length field, mode word bits 2:0
	localparam int MODE_W     = 12;
	localparam int BURST_W    = 4;   // holds 1, 2, 4 or 8
	localparam int NUM_BANKS  = 4;
	localparam int BANK_W     = 2;

	// nop cycles after reset before the first precharge
	localparam int INIT_WAIT  = 20;
	localparam int INIT_CNT_W = $clog2(INIT_WAIT);

	// burst length from the mode word code, anything above 3 runs as 8
	function automatic logic [BURST_W-1:0] burst_len_of(input logic [BL_CODE_W-1:0] code);
		logic [BURST_W-1:0] len;
		case (code)
			3'd0:    len = 4'd1;
			3'd1:    len = 4'd2;
			3'd2:    len = 4'd4;
			default: len = 4'd8;
		endcase
		return len;
	endfunction

endpackage

//--- src/sdc_init_ref.sv
// SDRAM power-up sequencer and refresh engine
// runs nop wait, precharge-all, two auto-refreshes and load mode, then
// serves latched refresh requests once no bank is busy

module sdc_init_ref
	import sdc_pkg::*;
(
	input  logic        clk,
	input  logic        rst2,
	input  logic        i_ref_set,
	input  sdc_timing_t i_timing,
	input  logic        i_any_busy,
	output sdc_cmd_e    o_cmd,
	output logic        o_owns_bus,
	output logic        o_ref_pending,
	output logic        o_init_done
);

	enum logic [2:0] {
		S_POWERUP,
		S_WAIT,
		S_PRECH,
		S_PRECH_WAIT,
		S_AREF,
		S_AREF_WAIT,
		S_LOAD_MODE,
		S_IDLE
	} state;

	logic [INIT_CNT_W-1:0] cnt;       // shared delay counter
	logic [1:0]            aref_cnt;  // refreshes issued during init
	logic                  init_done;
	logic                  ref_latch;
	logic                  cnt_end;
	logic                  ref_done;

	assign cnt_end  = (cnt == '0);
	assign ref_done = (state == S_AREF_WAIT) && cnt_end && init_done;

	////////////////////////////////////////////////////////////////////////////
	// sequencer
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst2)
	begin
		if (!rst2)
		begin
			state     <= S_POWERUP;
			cnt       <= '0;
			aref_cnt  <= '0;
			init_done <= 1'b0;
		end
		else
		begin
			case (state)
				S_POWERUP:
				begin
					state <= S_WAIT;
					cnt   <= INIT_CNT_W'(INIT_WAIT - 2);  // powerup cycle counts too
				end
				S_WAIT:
				begin
					cnt <= cnt - 1'b1;
					if (cnt_end)
						state <= S_PRECH;
				end
				S_PRECH:
				begin
					state <= S_PRECH_WAIT;
					cnt   <= INIT_CNT_W'(i_timing.trp) - 1'b1;
				end
				S_PRECH_WAIT:
				begin
					cnt <= cnt - 1'b1;
					if (cnt_end)
						state <= S_AREF;
				end
				S_AREF:
				begin
					state <= S_AREF_WAIT;
					cnt   <= INIT_CNT_W'(i_timing.trca) - 1'b1;
					if (!init_done)
						aref_cnt <= aref_cnt + 2'd1;
				end
				S_AREF_WAIT:
				begin
					cnt <= cnt - 1'b1;
					if (cnt_end)
					begin
						if (init_done)
							state <= S_IDLE;       // end of a normal refresh
						else if (aref_cnt == 2'd2)
							state <= S_LOAD_MODE;
						else
							state <= S_AREF;
					end
				end
				S_LOAD_MODE:
				begin
					state     <= S_IDLE;
					init_done <= 1'b1;
				end
				default:
				begin
					// wait for the running access to finish
					if (ref_latch && !i_any_busy)
						state <= S_PRECH;
				end
			endcase
		end
	end

	// refresh request latch, a new pulse wins over the clear
	always_ff @(posedge clk or negedge rst2)
	begin
		if (!rst2)
			ref_latch <= 1'b0;
		else if (i_ref_set)
			ref_latch <= 1'b1;
		else if (ref_done)
			ref_latch <= 1'b0;
	end

	always_comb
	begin
		case (state)
			S_PRECH:     o_cmd = CMD_PRECHARGE;
			S_AREF:      o_cmd = CMD_AUTO_REFRESH;
			S_LOAD_MODE: o_cmd = CMD_LOAD_MR;
			default:     o_cmd = CMD_NOP;
		endcase
	end

	assign o_owns_bus    = !init_done || (state != S_IDLE);
	assign o_ref_pending = ref_latch;
	assign o_init_done   = init_done;

endmodule

//--- src/sdc_bank_fsm.sv
// SDRAM single bank access machine
// activate, trcd wait, read/write burst, write recovery, precharge, trp wait

module sdc_bank_fsm
	import sdc_pkg::*;
(
	input  logic               clk,
	input  logic               rst2,
	input  logic               i_start,
	input  logic               i_wr_n,
	input  logic [BURST_W-1:0] i_burst_len,
	input  sdc_timing_t        i_timing,
	output sdc_cmd_e           o_cmd,
	output logic               o_busy,
	output logic               o_wr_next,
	output logic               o_rd_en
);

	enum logic [2:0] {
		S_IDLE,
		S_ACT,
		S_TRCD,
		S_COL,
		S_WREC,
		S_PRE,
		S_TRP
	} state;

	logic [BURST_W-1:0] cnt;     // delay down-count, beat up-count in S_COL
	logic               wr_n_q;  // direction of the running access

	always_ff @(posedge clk or negedge rst2)
	begin
		if (!rst2)
		begin
			state  <= S_IDLE;
			cnt    <= '0;
			wr_n_q <= 1'b1;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (i_start)
					begin
						state  <= S_ACT;
						wr_n_q <= i_wr_n;
					end
				end
				S_ACT:
				begin
					cnt <= '0;
					if (i_timing.trcd > 4'd1)
					begin
						state <= S_TRCD;
						cnt   <= i_timing.trcd - 4'd2;
					end
					else
						state <= S_COL;
				end
				S_TRCD:
				begin
					cnt <= cnt - 4'd1;
					if (cnt == '0)
					begin
						state <= S_COL;
						cnt   <= '0;             // beat count starts at zero
					end
				end
				S_COL:
				begin
					cnt <= cnt + 4'd1;
					if (cnt == i_burst_len - 4'd1)
					begin
						if (!wr_n_q && i_timing.twr > 4'd1)
						begin
							state <= S_WREC;
							cnt   <= i_timing.twr - 4'd2;
						end
						else
							state <= S_PRE;
					end
				end
				S_WREC:
				begin
					cnt <= cnt - 4'd1;
					if (cnt == '0)
						state <= S_PRE;
				end
				S_PRE:
				begin
					state <= S_TRP;
					cnt   <= i_timing.trp - 4'd1;
				end
				default:
				begin
					cnt <= cnt - 4'd1;
					if (cnt == '0)
						state <= S_IDLE;
				end
			endcase
		end
	end

	// column command on the first beat only
	always_comb
	begin
		case (state)
			S_ACT:   o_cmd = CMD_ACTIVE;
			S_COL:   o_cmd = (cnt != '0) ? CMD_NOP : (wr_n_q ? CMD_READ : CMD_WRITE);
			S_PRE:   o_cmd = CMD_PRECHARGE;
			default: o_cmd = CMD_NOP;
		endcase
	end

	assign o_busy    = (state != S_IDLE);
	assign o_rd_en   = (state == S_COL) && wr_n_q;
	assign o_wr_next = (state == S_COL) && !wr_n_q;

endmodule

//--- src/sdc_bank_arb.sv
// SDRAM bank selection and command multiplexing
// accepts a request only when init is done, no refresh waits and all banks
// are idle, then steers commands and strobes from the selected bank

module sdc_bank_arb
	import sdc_pkg::*;
(
	input  logic              clk,
	input  logic              rst2,
	input  logic              i_req,
	input  logic              i_wr_n,
	input  logic [BANK_W-1:0] i_bank,
	input  logic [MODE_W-1:0] i_mode_reg,
	input  sdc_timing_t       i_timing,
	input  sdc_cmd_e          i_init_cmd,
	input  logic              i_owns_bus,
	input  logic              i_ref_pending,
	input  logic              i_init_done,
	output sdc_cmd_e          o_cmd,
	output logic [BANK_W-1:0] o_bank,
	output logic              o_req_ack,
	output logic              o_wr_next,
	output logic              o_rd_en,
	output logic              o_any_busy
);

	sdc_cmd_e             bank_cmd [NUM_BANKS];
	logic [NUM_BANKS-1:0] bank_busy;
	logic [NUM_BANKS-1:0] bank_wr_next;
	logic [NUM_BANKS-1:0] bank_rd_en;
	logic [NUM_BANKS-1:0] bank_start;
	logic [BANK_W-1:0]    sel_bank;
	logic [BURST_W-1:0]   burst_len;
	logic                 accept;

	assign burst_len  = burst_len_of(i_mode_reg[BL_CODE_W-1:0]);
	assign o_any_busy = |bank_busy;
	assign accept     = i_req && i_init_done && !i_ref_pending && !o_any_busy;

	// selected bank stays until the next accepted request
	always_ff @(posedge clk or negedge rst2)
	begin
		if (!rst2)
		begin
			sel_bank  <= '0;
			o_req_ack <= 1'b0;
		end
		else
		begin
			o_req_ack <= accept;               // lines up with ACTIVE
			if (accept)
				sel_bank <= i_bank;
		end
	end

	for (genvar g = 0; g < NUM_BANKS; g++)
	begin : g_bank
		assign bank_start[g] = accept && (i_bank == BANK_W'(g));

		sdc_bank_fsm u_bank (
			.clk        (clk),
			.rst2       (rst2),
			.i_start    (bank_start[g]),
			.i_wr_n     (i_wr_n),
			.i_burst_len(burst_len),
			.i_timing   (i_timing),
			.o_cmd      (bank_cmd[g]),
			.o_busy     (bank_busy[g]),
			.o_wr_next  (bank_wr_next[g]),
			.o_rd_en    (bank_rd_en[g])
		);
	end

	assign o_cmd     = i_owns_bus ? i_init_cmd : bank_cmd[sel_bank];  // init/refresh first
	assign o_bank    = sel_bank;
	assign o_wr_next = bank_wr_next[sel_bank];
	assign o_rd_en   = bank_rd_en[sel_bank];

endmodule

//--- src/sdc_bnkctlr.sv
// SDRAM bank controller top
// joins the init/refresh sequencer with the bank arbiter

module sdc_bnkctlr
	import sdc_pkg::*;
(
	input  logic              clk,
	input  logic              rst2,
	input  logic              i_req,
	input  logic              i_wr_n,
	input  logic [BANK_W-1:0] i_bank,
	input  logic              i_ref_set,
	input  logic [MODE_W-1:0] i_mode_reg,
	input  sdc_timing_t       i_timing,
	output sdc_cmd_e          o_cmd,
	output logic [BANK_W-1:0] o_bank,
	output logic              o_req_ack,
	output logic              o_wr_next,
	output logic              o_rd_en,
	output logic              o_init_done
);

	sdc_cmd_e init_cmd;
	logic     owns_bus;
	logic     ref_pending;
	logic     any_busy;

	sdc_init_ref u_init_ref (
		.clk          (clk),
		.rst2         (rst2),
		.i_ref_set    (i_ref_set),
		.i_timing     (i_timing),
		.i_any_busy   (any_busy),
		.o_cmd        (init_cmd),
		.o_owns_bus   (owns_bus),
		.o_ref_pending(ref_pending),
		.o_init_done  (o_init_done)
	);

	sdc_bank_arb u_bank_arb (
		.clk          (clk),
		.rst2         (rst2),
		.i_req        (i_req),
		.i_wr_n       (i_wr_n),
		.i_bank       (i_bank),
		.i_mode_reg   (i_mode_reg),
		.i_timing     (i_timing),
		.i_init_cmd   (init_cmd),
		.i_owns_bus   (owns_bus),
		.i_ref_pending(ref_pending),
		.i_init_done  (o_init_done),
		.o_cmd        (o_cmd),
		.o_bank       (o_bank),
		.o_req_ack    (o_req_ack),
		.o_wr_next    (o_wr_next),
		.o_rd_en      (o_rd_en),
		.o_any_busy   (any_busy)
	);

endmodule

//--- tb/tb_sdc_checks.sv
// SDRAM bank controller reference model and checks
// predicts the command schedule of init, accesses and refresh every cycle
// and asserts the DUT outputs against it

module tb_sdc_checks
	import sdc_pkg::*;
(
	input  logic              clk,
	input  logic              rst2,
	input  logic              i_req,
	input  logic              i_wr_n,
	input  logic [BANK_W-1:0] i_bank,
	input  logic              i_ref_set,
	input  logic [MODE_W-1:0] i_mode_reg,
	input  sdc_timing_t       i_timing,
	input  sdc_cmd_e          i_cmd,
	input  logic [BANK_W-1:0] i_cmd_bank,
	input  logic              i_req_ack,
	input  logic              i_wr_next,
	input  logic              i_rd_en,
	input  logic              i_init_done,
	output int                o_err_cnt,
	output logic              o_idle
);

	int                err_cnt;
	int                cyc;                      // cycles since reset release
	int                lmr;                      // cycle of LOAD_MR
	int                act, col, last, pre, free;  // access schedule
	int                rpre, raref, rfree;       // refresh schedule
	logic              acc_on;
	logic              acc_wr;
	logic              ref_on;
	logic              ref_pend;
	logic [BANK_W-1:0] acc_bank;
	sdc_cmd_e          want_cmd;
	logic              want_ack;
	logic              want_rd;
	logic              want_wr;

	assign o_err_cnt = err_cnt;

	// 1, 2, 4 or 8 beats, codes above 3 give 8
	function automatic int beats_for_code(input logic [BL_CODE_W-1:0] code);
		if (code < 3'd4)
			return 1 << code;
		return 8;
	endfunction

	task automatic report_mismatch(input string what, input int got, input int want);
		$display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, want);
		err_cnt++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// per cycle prediction, outputs sampled before the edge updates them
	////////////////////////////////////////////////////////////////////////////
	initial
		err_cnt = 0;

	always @(posedge clk)
	begin
		if (!rst2)
		begin
			assert (i_cmd == CMD_NOP)
				else report_mismatch("command in reset", int'(i_cmd), int'(CMD_NOP));
			assert ({i_rd_en, i_wr_next, i_req_ack} == 3'b000)
				else report_mismatch("strobes in reset", int'({i_rd_en, i_wr_next, i_req_ack}), 0);
			assert (!i_init_done)
				else report_mismatch("init done in reset", int'(i_init_done), 0);
			cyc      = 0;
			acc_on   = 1'b0;
			ref_on   = 1'b0;
			ref_pend = 1'b0;
			o_idle   = 1'b0;
		end
		else
		begin
			lmr = INIT_WAIT + int'(i_timing.trp) + 2 * int'(i_timing.trca) + 3;
			if (ref_on && cyc == rfree)
			begin
				ref_on   = 1'b0;
				ref_pend = 1'b0;
			end
			if (acc_on && cyc == free)
				acc_on = 1'b0;

			want_cmd = CMD_NOP;
			want_ack = 1'b0;
			if (cyc == INIT_WAIT)
				want_cmd = CMD_PRECHARGE;
			else if (cyc == INIT_WAIT + int'(i_timing.trp) + 1 || cyc == lmr - int'(i_timing.trca) - 1)
				want_cmd = CMD_AUTO_REFRESH;
			else if (cyc == lmr)
				want_cmd = CMD_LOAD_MR;
			if (acc_on && cyc == act)
			begin
				want_cmd = CMD_ACTIVE;
				want_ack = 1'b1;
			end
			else if (acc_on && cyc == col)
				want_cmd = acc_wr ? CMD_WRITE : CMD_READ;
			else if (acc_on && cyc == pre)
				want_cmd = CMD_PRECHARGE;
			if (ref_on && cyc == rpre)
				want_cmd = CMD_PRECHARGE;
			else if (ref_on && cyc == raref)
				want_cmd = CMD_AUTO_REFRESH;
			want_rd = acc_on && !acc_wr && cyc >= col && cyc <= last;
			want_wr = acc_on && acc_wr && cyc >= col && cyc <= last;

			assert (i_cmd == want_cmd) else report_mismatch("command", int'(i_cmd), int'(want_cmd));
			assert (i_req_ack == want_ack)
				else report_mismatch("request acknowledge", int'(i_req_ack), int'(want_ack));
			assert (i_rd_en == want_rd) else report_mismatch("read strobe", int'(i_rd_en), int'(want_rd));
			assert (i_wr_next == want_wr)
				else report_mismatch("write strobe", int'(i_wr_next), int'(want_wr));
			assert (i_init_done == (cyc > lmr))
				else report_mismatch("init done", int'(i_init_done), int'(cyc > lmr));
			if (acc_on && cyc >= act && cyc <= pre)
				assert (i_cmd_bank == acc_bank)
					else report_mismatch("bank", int'(i_cmd_bank), int'(acc_bank));

			// refresh waits for the bank, a request waits for both
			if (ref_pend && !ref_on && !acc_on && cyc > lmr)
			begin
				ref_on = 1'b1;
				rpre   = cyc + 1;
				raref  = rpre + int'(i_timing.trp) + 1;
				rfree  = raref + int'(i_timing.trca) + 1;
			end
			else if (i_req && cyc > lmr && !ref_pend && !acc_on)
			begin
				acc_on   = 1'b1;
				acc_wr   = !i_wr_n;
				acc_bank = i_bank;
				act      = cyc + 1;
				col      = act + int'(i_timing.trcd);
				last     = col + beats_for_code(i_mode_reg[BL_CODE_W-1:0]) - 1;
				pre      = last + (acc_wr ? int'(i_timing.twr) : 1);
				free     = pre + int'(i_timing.trp) + 1;
			end
			if (i_ref_set)
				ref_pend = 1'b1;

			o_idle = (cyc + 1 > lmr) && !ref_pend && !(acc_on && cyc + 1 < free);
			cyc++;
		end
	end

endmodule

//--- tb/tb_sdc_bnkctlr.sv
// SDRAM bank controller testbench
// random timing, single reads and writes, back-to-back requests and refresh
// during an access, checked by the model in tb_sdc_checks

module tb_sdc_bnkctlr
	import sdc_pkg::*;
();

	localparam int N_RD     = 4;
	localparam int N_WR     = 4;
	localparam int N_PAIR   = 2;
	localparam int N_REF    = 2;
	localparam int N_OPS    = N_RD + N_WR + 2 * N_PAIR + 3 * N_REF;
	localparam int WDOG_CYC = 200 + 60 * N_OPS;

	logic              clk;
	logic              rst2;
	logic              req;
	logic              wr_n;
	logic [BANK_W-1:0] bank;
	logic              ref_set;
	logic [MODE_W-1:0] mode_reg;
	sdc_timing_t       timing;
	sdc_cmd_e          cmd;
	logic [BANK_W-1:0] cmd_bank;
	logic              req_ack;
	logic              wr_next;
	logic              rd_en;
	logic              init_done;
	int                err_cnt;
	logic              idle;
	int                err_base;
	int                pass_cnt;
	int                fail_cnt;

	always #10 clk = ~clk;

	sdc_bnkctlr UUT (
		.clk        (clk),
		.rst2       (rst2),
		.i_req      (req),
		.i_wr_n     (wr_n),
		.i_bank     (bank),
		.i_ref_set  (ref_set),
		.i_mode_reg (mode_reg),
		.i_timing   (timing),
		.o_cmd      (cmd),
		.o_bank     (cmd_bank),
		.o_req_ack  (req_ack),
		.o_wr_next  (wr_next),
		.o_rd_en    (rd_en),
		.o_init_done(init_done)
	);

	tb_sdc_checks u_checks (
		.clk        (clk),
		.rst2       (rst2),
		.i_req      (req),
		.i_wr_n     (wr_n),
		.i_bank     (bank),
		.i_ref_set  (ref_set),
		.i_mode_reg (mode_reg),
		.i_timing   (timing),
		.i_cmd      (cmd),
		.i_cmd_bank (cmd_bank),
		.i_req_ack  (req_ack),
		.i_wr_next  (wr_next),
		.i_rd_en    (rd_en),
		.i_init_done(init_done),
		.o_err_cnt  (err_cnt),
		.o_idle     (idle)
	);

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers, all called and returning on a falling edge
	////////////////////////////////////////////////////////////////////////////
	task automatic wait_ack(output bit ok);
		ok = 1'b0;
		for (int n = 0; n < 100 && !ok; n++)
		begin
			@(negedge clk);
			ok = req_ack;
		end
		if (!ok)
			$display("no request acknowledge within 100 cycles");
	endtask

	task automatic wait_idle(input int limit, output bit ok);
		ok = 1'b0;
		for (int n = 0; n < limit && !ok; n++)
		begin
			@(negedge clk);
			ok = idle;
		end
		if (!ok)
			$display("controller not idle within %0d cycles", limit);
	endtask

	// new burst code only here, while no bank runs
	task automatic start_access(input logic [BANK_W-1:0] b, input logic wn, output bit ok);
		mode_reg = MODE_W'($urandom);
		mode_reg[BL_CODE_W-1:0] = 3'($urandom % 4);
		bank = b;
		wr_n = wn;
		req  = 1'b1;
		wait_ack(ok);
		req = 1'b0;
	endtask

	task automatic finish_test(input string name, input bit ok);
		if (ok && err_cnt == err_base)
		begin
			pass_cnt++;
			$display("test %s passed", name);
		end
		else
		begin
			fail_cnt++;
			$display("test %s failed", name);
		end
		err_base = err_cnt;
	endtask

	initial
	begin
		#(WDOG_CYC * 20);
		$display("run timed out after %0d cycles", WDOG_CYC);
		$display("Something failed");
		$finish;
	end

	initial
	begin
		bit                ok;
		bit                ok_b;
		bit                ok_c;
		logic [BANK_W-1:0] first;

		void'($urandom(32'h23af_4ecb));
		clk         = 1'b0;
		rst2        = 1'b0;
		req         = 1'b0;
		wr_n        = 1'b1;
		bank        = '0;
		ref_set     = 1'b0;
		mode_reg    = '0;
		timing.trp  = 4'(1 + $urandom % 4);
		timing.trcd = 4'(1 + $urandom % 4);
		timing.trca = 4'(1 + $urandom % 4);
		timing.twr  = 4'(1 + $urandom % 4);
		err_base    = 0;
		pass_cnt    = 0;
		fail_cnt    = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst2 = 1'b1;

		wait_idle(200, ok);
		finish_test("init", ok && init_done);

		for (int i = 0; i < N_RD + N_WR; i++)
		begin
			start_access(2'($urandom % 4), i < N_RD, ok);
			wait_idle(100, ok_b);
			finish_test($sformatf("%s %0d", i < N_RD ? "read" : "write", i), ok && ok_b);
		end

		// second request held while the first bank runs
		for (int i = 0; i < N_PAIR; i++)
		begin
			first = 2'($urandom % 4);
			start_access(first, 1'($urandom % 2), ok);
			bank = 2'(first + 1 + $urandom % 3);
			wr_n = 1'($urandom % 2);
			req  = 1'b1;
			wait_ack(ok_b);
			req = 1'b0;
			wait_idle(100, ok_c);
			finish_test($sformatf("back-to-back %0d", i), ok && ok_b && ok_c);
		end

		// refresh pulse during an access, next request waits for it
		for (int i = 0; i < N_REF; i++)
		begin
			first = 2'($urandom % 4);
			start_access(first, 1'($urandom % 2), ok);
			ref_set = 1'b1;
			bank    = 2'(first + 1 + $urandom % 3);
			req     = 1'b1;
			@(negedge clk);
			ref_set = 1'b0;
			wait_ack(ok_b);
			req = 1'b0;
			wait_idle(100, ok_c);
			finish_test($sformatf("refresh %0d", i), ok && ok_b && ok_c);
		end

		$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == err_base)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- tb.f
src/sdc_pkg.sv
src/sdc_init_ref.sv
src/sdc_bank_fsm.sv
src/sdc_bank_arb.sv
src/sdc_bnkctlr.sv
tb/tb_sdc_checks.sv
tb/tb_sdc_bnkctlr.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_sdc_bnkctlr
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert
PASS_TEXT ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
